// ==== hw/noc_shell_cfg.svh ====
`ifndef NOC_SHELL_CFG_SVH
`define NOC_SHELL_CFG_SVH

// Block identity returned on the NoC ID readback
`define NOC_SHELL_NOC_ID 64'hDEAD_BEEF_0123_4567

// Port counts packed into the global parameters word
`define NOC_SHELL_IN_PORTS  1
`define NOC_SHELL_OUT_PORTS 1

// Readback word for any select the shell does not decode
`define NOC_SHELL_BAD_RB 64'h0BAD_C0DE_0BAD_C0DE

// Beats in a command or acknowledge packet (header + one word)
`define NOC_SHELL_CMD_BEATS 2

`endif

// ==== hw/chdr_pkg.sv ====
package chdr_pkg;

   // Packet type, top two bits of the first-beat header
   typedef enum logic [1:0] {
      PKT_DATA = 2'd0,
      PKT_FC   = 2'd1,
      PKT_CMD  = 2'd2,
      PKT_ACK  = 2'd3
   } pkt_type_e;

   typedef struct packed {
      pkt_type_e   pkt_type;
      logic [1:0]  flags;
      logic [11:0] seqnum;
      logic [15:0] len;
      logic [15:0] src_sid;
      logic [15:0] dst_sid;
   } chdr_hdr_t;

   // Second beat of a command packet
   typedef struct packed {
      logic [23:0] pad;
      logic [7:0]  addr;
      logic [31:0] data;
   } cmd_word_t;

   // One bus beat, a header on the first beat and a command word after it
   typedef union packed {
      chdr_hdr_t hdr;
      cmd_word_t cmd;
   } chdr_beat_u;

endpackage

// ==== hw/shell_regs_pkg.sv ====
package shell_regs_pkg;

   // Settings bus addresses owned by the shell
   localparam logic [7:0] SR_RB_ADDR      = 8'd124;
   localparam logic [7:0] SR_RB_ADDR_USER = 8'd125;
   localparam logic [7:0] SR_SRC_SID      = 8'd128;
   localparam logic [7:0] SR_NEXT_DST_SID = 8'd129;
   localparam logic [7:0] SR_CLEAR_TX_FC  = 8'd130;

   // Readback selects, written through SR_RB_ADDR
   typedef enum logic [2:0] {
      RB_NOC_ID          = 3'd0,
      RB_GLOBAL_PARAMS   = 3'd1,
      RB_BLOCK_PORT_SIDS = 3'd4,
      RB_USER_RB_DATA    = 3'd5
   } rb_sel_e;

endpackage

// ==== hw/noc_shell_ifs.sv ====
`timescale 1ns/10ps

// Beat stream with valid/ready handshake
interface axis_if;
   import chdr_pkg::*;

   chdr_beat_u tdata;
   logic       tlast;
   logic       tvalid;
   logic       tready;

   modport src (output tdata, output tlast, output tvalid, input tready);
   modport snk (input tdata, input tlast, input tvalid, output tready);
endinterface

// Settings bus write side plus readback return
interface settings_if;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic        rb_valid;
   logic [63:0] rb_data;

   modport master (
      output set_stb, output set_addr, output set_data,
      input  rb_valid, input rb_data
   );
   modport slave (
      input  set_stb, input set_addr, input set_data,
      output rb_valid, output rb_data
   );
endinterface

// ==== hw/pkt_type_demux.sv ====
`timescale 1ns/10ps

module pkt_type_demux (
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] i_tdata,
   input  logic        i_tlast,
   input  logic        i_tvalid,
   output logic        o_tready,
   output logic [63:0] o_data_tdata,
   output logic        o_data_tlast,
   output logic        o_data_tvalid,
   input  logic        i_data_tready,
   axis_if.src         o_cmd
);
   import chdr_pkg::*;

   chdr_beat_u in_beat;
   logic       first_beat;
   pkt_type_e  route_q;
   pkt_type_e  route;

   assign in_beat = i_tdata;

   // Route comes straight from the header on the first beat, then from the latch
   assign route = first_beat ? in_beat.hdr.pkt_type : route_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         first_beat <= 1'b1;
         route_q    <= PKT_DATA;
      end else if (i_tvalid && o_tready) begin
         first_beat <= i_tlast;
         if (first_beat)
            route_q <= in_beat.hdr.pkt_type;
      end
   end

   assign o_data_tdata  = i_tdata;
   assign o_data_tlast  = i_tlast;
   assign o_data_tvalid = i_tvalid && (route == PKT_DATA);

   assign o_cmd.tdata  = in_beat;
   assign o_cmd.tlast  = i_tlast;
   assign o_cmd.tvalid = i_tvalid && (route == PKT_CMD);

   // FC and ACK packets are swallowed one beat per cycle
   always_comb begin
      case (route)
         PKT_DATA: o_tready = i_data_tready;
         PKT_CMD:  o_tready = o_cmd.tready;
         default:  o_tready = 1'b1;
      endcase
   end

endmodule

// ==== hw/cmd_pkt_proc.sv ====
`timescale 1ns/10ps
`include "noc_shell_cfg.svh"

module cmd_pkt_proc (
   input  logic       clk,
   input  logic       reset,
   axis_if.snk        i_cmd,
   axis_if.src        o_ack,
   settings_if.master o_set
);
   import chdr_pkg::*;

   typedef enum logic [2:0] {
      S_HDR,
      S_WORD,
      S_STB,
      S_WAIT_RB,
      S_ACK_HDR,
      S_ACK_WORD
   } state_e;

   state_e      state;
   chdr_hdr_t   cmd_hdr;
   cmd_word_t   cmd_word;
   logic [63:0] rb_word;
   chdr_hdr_t   ack_hdr;
   logic        cmd_take;

   assign i_cmd.tready = (state == S_HDR) || (state == S_WORD);
   assign cmd_take     = i_cmd.tvalid && i_cmd.tready;

   //////////////////////////////////////////////////////////////////////
   // Command FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_HDR;
      end else begin
         case (state)
            S_HDR: begin
               // A lone header beat holds no command word, so it is dropped
               if (cmd_take && !i_cmd.tlast)
                  state <= S_WORD;
            end
            S_WORD: begin
               if (cmd_take)
                  state <= S_STB;
            end
            S_STB:   state <= S_WAIT_RB;
            // Readback was cleared by the strobe, so this waits for fresh data
            S_WAIT_RB: begin
               if (o_set.rb_valid)
                  state <= S_ACK_HDR;
            end
            S_ACK_HDR: begin
               if (o_ack.tready)
                  state <= S_ACK_WORD;
            end
            S_ACK_WORD: begin
               if (o_ack.tready)
                  state <= S_HDR;
            end
            default: state <= S_HDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_take && (state == S_HDR))
         cmd_hdr <= i_cmd.tdata.hdr;
      if (cmd_take && (state == S_WORD))
         cmd_word <= i_cmd.tdata.cmd;
      if ((state == S_WAIT_RB) && o_set.rb_valid)
         rb_word <= o_set.rb_data;
   end

   assign o_set.set_stb  = (state == S_STB);
   assign o_set.set_addr = cmd_word.addr;
   assign o_set.set_data = cmd_word.data;

   //////////////////////////////////////////////////////////////////////
   // Acknowledge packet
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      ack_hdr          = '0;
      ack_hdr.pkt_type = PKT_ACK;
      ack_hdr.seqnum   = cmd_hdr.seqnum;
      ack_hdr.len      = 16'(`NOC_SHELL_CMD_BEATS * 8);
      // SIDs swap so the ack returns to the sender
      ack_hdr.src_sid  = cmd_hdr.dst_sid;
      ack_hdr.dst_sid  = cmd_hdr.src_sid;
   end

   assign o_ack.tvalid = (state == S_ACK_HDR) || (state == S_ACK_WORD);
   assign o_ack.tlast  = (state == S_ACK_WORD);
   assign o_ack.tdata  = (state == S_ACK_WORD) ? chdr_beat_u'(rb_word)
                                               : chdr_beat_u'(ack_hdr);

endmodule

// ==== hw/shell_regs.sv ====
`timescale 1ns/10ps
`include "noc_shell_cfg.svh"

module shell_regs (
   input  logic        clk,
   input  logic        reset,
   settings_if.slave   i_set,
   input  logic        i_rb_stb,
   input  logic [63:0] i_rb_data,
   output logic [7:0]  o_rb_addr,
   output logic [15:0] o_src_sid,
   output logic [15:0] o_next_dst_sid,
   output logic        o_clear_tx_seqnum
);
   import shell_regs_pkg::*;

   logic [2:0] rb_sel;

   //////////////////////////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         rb_sel            <= 3'd0;
         o_rb_addr         <= 8'd0;
         o_src_sid         <= 16'd0;
         o_next_dst_sid    <= 16'd0;
         o_clear_tx_seqnum <= 1'b0;
      end else begin
         o_clear_tx_seqnum <= i_set.set_stb && (i_set.set_addr == SR_CLEAR_TX_FC);
         if (i_set.set_stb) begin
            case (i_set.set_addr)
               SR_RB_ADDR:      rb_sel         <= i_set.set_data[2:0];
               SR_RB_ADDR_USER: o_rb_addr      <= i_set.set_data[7:0];
               SR_SRC_SID:      o_src_sid      <= i_set.set_data[15:0];
               SR_NEXT_DST_SID: o_next_dst_sid <= i_set.set_data[15:0];
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registered readback mux
   //////////////////////////////////////////////////////////////////////

   // Any write drops valid so the old word is never mistaken for the new one
   always_ff @(posedge clk) begin
      if (reset || i_set.set_stb)
         i_set.rb_valid <= 1'b0;
      else
         i_set.rb_valid <= (rb_sel == RB_USER_RB_DATA) ? i_rb_stb : 1'b1;
   end

   always_ff @(posedge clk) begin
      case (rb_sel)
         RB_NOC_ID:          i_set.rb_data <= `NOC_SHELL_NOC_ID;
         RB_GLOBAL_PARAMS:   i_set.rb_data <= {48'd0, 3'd0, 5'(`NOC_SHELL_IN_PORTS),
                                               3'd0, 5'(`NOC_SHELL_OUT_PORTS)};
         RB_BLOCK_PORT_SIDS: i_set.rb_data <= {o_src_sid, o_next_dst_sid, 32'd0};
         RB_USER_RB_DATA:    i_set.rb_data <= i_rb_data;
         default:            i_set.rb_data <= `NOC_SHELL_BAD_RB;
      endcase
   end

endmodule

// ==== hw/pkt_out_arbiter.sv ====
`timescale 1ns/10ps

module pkt_out_arbiter (
   input  logic        clk,
   input  logic        reset,
   axis_if.snk         i_ack,
   input  logic [63:0] i_src_tdata,
   input  logic        i_src_tlast,
   input  logic        i_src_tvalid,
   output logic        o_src_tready,
   output logic [63:0] o_tdata,
   output logic        o_tlast,
   output logic        o_tvalid,
   input  logic        i_tready
);

   logic        last_src;      // 1 when the stream source was granted last
   logic        locked;
   logic        sel;
   logic        sel_valid;
   logic        sel_last;
   logic [63:0] sel_data;
   logic        can_load;
   logic        take;

   // Grant stays put mid-packet, alternates when both sides wait
   always_comb begin
      if (locked)
         sel = last_src;
      else if (i_ack.tvalid && i_src_tvalid)
         sel = ~last_src;
      else
         sel = i_src_tvalid;
   end

   assign sel_valid = sel ? i_src_tvalid : i_ack.tvalid;
   assign sel_last  = sel ? i_src_tlast  : i_ack.tlast;
   assign sel_data  = sel ? i_src_tdata  : i_ack.tdata;

   // Output register refills when empty or draining this cycle
   assign can_load     = !o_tvalid || i_tready;
   assign take         = can_load && sel_valid;
   assign i_ack.tready = can_load && !sel;
   assign o_src_tready = can_load && sel;

   always_ff @(posedge clk) begin
      if (reset) begin
         last_src <= 1'b0;
         locked   <= 1'b0;
         o_tvalid <= 1'b0;
      end else begin
         if (take) begin
            last_src <= sel;
            locked   <= !sel_last;
         end
         if (can_load)
            o_tvalid <= sel_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         o_tdata <= sel_data;
         o_tlast <= sel_last;
      end
   end

endmodule

// ==== hw/noc_shell.sv ====
`timescale 1ns/10ps

module noc_shell (
   input  logic        clk,
   input  logic        reset,
   // Crossbar side
   input  logic [63:0] i_i_tdata,
   input  logic        i_i_tlast,
   input  logic        i_i_tvalid,
   output logic        o_i_tready,
   output logic [63:0] o_o_tdata,
   output logic        o_o_tlast,
   output logic        o_o_tvalid,
   input  logic        i_o_tready,
   // Stream sink and source
   output logic [63:0] o_str_sink_tdata,
   output logic        o_str_sink_tlast,
   output logic        o_str_sink_tvalid,
   input  logic        i_str_sink_tready,
   input  logic [63:0] i_str_src_tdata,
   input  logic        i_str_src_tlast,
   input  logic        i_str_src_tvalid,
   output logic        o_str_src_tready,
   // Settings bus and user readback
   output logic        o_set_stb,
   output logic [7:0]  o_set_addr,
   output logic [31:0] o_set_data,
   input  logic        i_rb_stb,
   input  logic [63:0] i_rb_data,
   output logic [7:0]  o_rb_addr,
   output logic [15:0] o_src_sid,
   output logic [15:0] o_next_dst_sid,
   output logic        o_clear_tx_seqnum
);

   axis_if     cmd_s ();
   axis_if     ack_s ();
   settings_if set_bus ();

   pkt_type_demux pkt_type_demux_i (
      .clk           (clk),
      .reset         (reset),
      .i_tdata       (i_i_tdata),
      .i_tlast       (i_i_tlast),
      .i_tvalid      (i_i_tvalid),
      .o_tready      (o_i_tready),
      .o_data_tdata  (o_str_sink_tdata),
      .o_data_tlast  (o_str_sink_tlast),
      .o_data_tvalid (o_str_sink_tvalid),
      .i_data_tready (i_str_sink_tready),
      .o_cmd         (cmd_s)
   );

   cmd_pkt_proc cmd_pkt_proc_i (
      .clk   (clk),
      .reset (reset),
      .i_cmd (cmd_s),
      .o_ack (ack_s),
      .o_set (set_bus)
   );

   shell_regs shell_regs_i (
      .clk               (clk),
      .reset             (reset),
      .i_set             (set_bus),
      .i_rb_stb          (i_rb_stb),
      .i_rb_data         (i_rb_data),
      .o_rb_addr         (o_rb_addr),
      .o_src_sid         (o_src_sid),
      .o_next_dst_sid    (o_next_dst_sid),
      .o_clear_tx_seqnum (o_clear_tx_seqnum)
   );

   pkt_out_arbiter pkt_out_arbiter_i (
      .clk          (clk),
      .reset        (reset),
      .i_ack        (ack_s),
      .i_src_tdata  (i_str_src_tdata),
      .i_src_tlast  (i_str_src_tlast),
      .i_src_tvalid (i_str_src_tvalid),
      .o_src_tready (o_str_src_tready),
      .o_tdata      (o_o_tdata),
      .o_tlast      (o_o_tlast),
      .o_tvalid     (o_o_tvalid),
      .i_tready     (i_o_tready)
   );

   // Every settings write is also visible to the user logic
   assign o_set_stb  = set_bus.set_stb;
   assign o_set_addr = set_bus.set_addr;
   assign o_set_data = set_bus.set_data;

endmodule

// ==== bench/noc_shell_properties.sv ====
`timescale 1ns/10ps

module noc_shell_properties (
   input logic        clk,
   input logic        reset,
   input logic [63:0] i_i_tdata,
   input logic        i_i_tlast,
   input logic        i_i_tvalid,
   input logic        o_i_tready,
   input logic [63:0] o_o_tdata,
   input logic        o_o_tlast,
   input logic        o_o_tvalid,
   input logic        i_o_tready,
   input logic [63:0] o_str_sink_tdata,
   input logic        o_str_sink_tvalid,
   input logic        i_str_sink_tready,
   input logic        o_set_stb
);

   int   fail_count = 0;
   logic in_first;
   logic out_first;
   logic cmd_pending;

   // Packet boundaries on both sides, and a command that stays open
   // from its strobe until its acknowledge header leaves the block
   always_ff @(posedge clk) begin
      if (reset) begin
         in_first    <= 1'b1;
         out_first   <= 1'b1;
         cmd_pending <= 1'b0;
      end else begin
         if (i_i_tvalid && o_i_tready)
            in_first <= i_i_tlast;
         if (o_o_tvalid && i_o_tready)
            out_first <= o_o_tlast;
         if (o_set_stb)
            cmd_pending <= 1'b1;
         else if (o_o_tvalid && i_o_tready && out_first && o_o_tdata[63:62] == 2'd3)
            cmd_pending <= 1'b0;
      end
   end

   // Output beat must wait unchanged while the crossbar stalls
   out_hold: assert property (@(posedge clk) disable iff (reset)
      o_o_tvalid && !i_o_tready |=> o_o_tvalid && $stable(o_o_tdata))
      else begin
         fail_count++;
         $error("output beat changed under back-pressure");
      end

   sink_hold: assert property (@(posedge clk) disable iff (reset)
      o_str_sink_tvalid && !i_str_sink_tready
         |=> o_str_sink_tvalid && $stable(o_str_sink_tdata))
      else begin
         fail_count++;
         $error("sink beat changed under back-pressure");
      end

   stb_single: assert property (@(posedge clk) disable iff (reset)
      o_set_stb |=> !o_set_stb)
      else begin
         fail_count++;
         $error("settings strobe lasted two cycles");
      end

   // A new command header must wait while one is still being served
   cmd_blocked: assert property (@(posedge clk) disable iff (reset)
      (o_set_stb || cmd_pending) && i_i_tvalid && in_first && i_i_tdata[63:62] == 2'd2
         |-> !o_i_tready)
      else begin
         fail_count++;
         $error("command accepted while another was pending");
      end

endmodule

// ==== bench/noc_shell_checker.sv ====
`timescale 1ns/10ps
`include "noc_shell_cfg.svh"

module noc_shell_checker (
   input logic        clk,
   input logic        reset,
   input logic [63:0] i_i_tdata,
   input logic        i_i_tlast,
   input logic        i_i_tvalid,
   input logic        o_i_tready,
   input logic [63:0] o_o_tdata,
   input logic        o_o_tlast,
   input logic        o_o_tvalid,
   input logic        i_o_tready,
   input logic [63:0] o_str_sink_tdata,
   input logic        o_str_sink_tlast,
   input logic        o_str_sink_tvalid,
   input logic        i_str_sink_tready,
   input logic [63:0] i_str_src_tdata,
   input logic        i_str_src_tlast,
   input logic        i_str_src_tvalid,
   input logic        o_str_src_tready,
   input logic        o_set_stb,
   input logic [7:0]  o_set_addr,
   input logic [31:0] o_set_data,
   input logic        i_rb_stb,
   input logic [63:0] i_rb_data,
   input logic [7:0]  o_rb_addr,
   input logic [15:0] o_src_sid,
   input logic [15:0] o_next_dst_sid,
   input logic        o_clear_tx_seqnum
);

   logic [64:0] sink_q[$];
   logic [64:0] ack_q[$];
   logic [64:0] src_q[$];
   logic [39:0] set_q[$];
   logic [63:0] cmd_hdr;
   logic [63:0] pend_hdr;
   logic [15:0] m_src_sid;
   logic [15:0] m_next_dst;
   logic [7:0]  m_rb_addr;
   logic [2:0]  m_rb_sel;
   logic [1:0]  in_type;
   logic        in_first;
   logic        out_first;
   logic        out_owner;
   logic        clr_exp;
   logic        rb_pending;
   int          err_count;
   int          test_errs;
   int          test_num;
   int          tests_failed;

   initial begin
      err_count    = 0;
      test_errs    = 0;
      test_num     = 0;
      tests_failed = 0;
   end

   task automatic value_error(input string msg);
      err_count++;
      test_errs++;
      $display("Error %0t: %s", $time, msg);
   endtask

   // One line per finished test
   task automatic end_test(input string name);
      test_num++;
      if (test_errs != 0)
         tests_failed++;
      $display("Test %0d %s: %s (%0d errors)", test_num, name,
               (test_errs == 0) ? "ok" : "failed", test_errs);
      test_errs = 0;
   endtask

   function automatic logic idle();
      return (sink_q.size() == 0) && (ack_q.size() == 0) && (src_q.size() == 0) &&
             (set_q.size() == 0) && !rb_pending && in_first && out_first;
   endfunction

   // Readback word by select, from the register map rules
   function automatic logic [63:0] rb_word(input logic [2:0] sel);
      case (sel)
         3'd0:    return `NOC_SHELL_NOC_ID;
         3'd1:    return 64'h0101;
         3'd4:    return {m_src_sid, m_next_dst, 32'd0};
         default: return `NOC_SHELL_BAD_RB;
      endcase
   endfunction

   task automatic push_ack(input logic [63:0] hdr, input logic [63:0] word);
      logic [63:0] ack;
      ack = {2'd3, 2'd0, hdr[59:48], 16'd16, hdr[15:0], hdr[31:16]};
      ack_q.push_back({1'b0, ack});
      ack_q.push_back({1'b1, word});
   endtask

   always @(posedge clk) begin
      logic [64:0] beat;
      logic [64:0] exp;
      logic [39:0] wr;
      if (reset) begin
         in_first   = 1'b1;
         out_first  = 1'b1;
         rb_pending = 1'b0;
         clr_exp    = 1'b0;
         m_src_sid  = '0;
         m_next_dst = '0;
         m_rb_addr  = '0;
         m_rb_sel   = '0;
      end else begin
         if (o_src_sid !== m_src_sid || o_next_dst_sid !== m_next_dst)
            value_error($sformatf("SIDs %h/%h, expected %h/%h", o_src_sid,
                                  o_next_dst_sid, m_src_sid, m_next_dst));
         if (o_rb_addr !== m_rb_addr)
            value_error($sformatf("rb_addr %h, expected %h", o_rb_addr, m_rb_addr));
         if (o_clear_tx_seqnum !== clr_exp)
            value_error($sformatf("clear_tx_seqnum %b, expected %b",
                                  o_clear_tx_seqnum, clr_exp));
         clr_exp = 1'b0;

         ////////////////////////////////////////////////////////////////////
         // Input side builds the expectations
         ////////////////////////////////////////////////////////////////////
         if (i_i_tvalid && o_i_tready) begin
            if (in_first)
               in_type = i_i_tdata[63:62];
            if (in_type == 2'd0)
               sink_q.push_back({i_i_tlast, i_i_tdata});
            else if (in_type == 2'd2 && in_first)
               cmd_hdr = i_i_tdata;
            else if (in_type == 2'd2)
               set_q.push_back({i_i_tdata[39:32], i_i_tdata[31:0]});
            in_first = i_i_tlast;
         end

         if (o_str_sink_tvalid && i_str_sink_tready) begin
            beat = {o_str_sink_tlast, o_str_sink_tdata};
            if (sink_q.size() == 0)
               value_error($sformatf("unexpected sink beat %h", beat));
            else begin
               exp = sink_q.pop_front();
               if (beat !== exp)
                  value_error($sformatf("sink beat %h, expected %h", beat, exp));
            end
         end

         // User readback arrives some cycles after the strobe
         if (rb_pending && i_rb_stb) begin
            push_ack(pend_hdr, i_rb_data);
            rb_pending = 1'b0;
         end

         if (o_set_stb) begin
            if (set_q.size() == 0)
               value_error("settings strobe without a command");
            else begin
               wr = set_q.pop_front();
               if ({o_set_addr, o_set_data} !== wr)
                  value_error($sformatf("set write %h:%h, expected %h:%h", o_set_addr,
                                        o_set_data, wr[39:32], wr[31:0]));
               clr_exp = (wr[39:32] == 8'd130);
               case (wr[39:32])
                  8'd124:  m_rb_sel   = wr[2:0];
                  8'd125:  m_rb_addr  = wr[7:0];
                  8'd128:  m_src_sid  = wr[15:0];
                  8'd129:  m_next_dst = wr[15:0];
                  default: ;
               endcase
               if (m_rb_sel == 3'd5) begin
                  rb_pending = 1'b1;
                  pend_hdr   = cmd_hdr;
               end else
                  push_ack(cmd_hdr, rb_word(m_rb_sel));
            end
         end

         if (i_str_src_tvalid && o_str_src_tready)
            src_q.push_back({i_str_src_tlast, i_str_src_tdata});

         ////////////////////////////////////////////////////////////////////
         // Output side, whole packets from one source at a time
         ////////////////////////////////////////////////////////////////////
         if (o_o_tvalid && i_o_tready) begin
            beat = {o_o_tlast, o_o_tdata};
            if (out_first) begin
               if (ack_q.size() != 0 && ack_q[0] === beat)
                  out_owner = 1'b0;
               else if (src_q.size() != 0 && src_q[0] === beat)
                  out_owner = 1'b1;
               else
                  value_error($sformatf("unexpected output beat %h", beat));
            end
            if (out_owner && src_q.size() != 0) begin
               exp = src_q.pop_front();
               if (beat !== exp)
                  value_error($sformatf("source beat %h, expected %h", beat, exp));
            end else if (!out_owner && ack_q.size() != 0) begin
               exp = ack_q.pop_front();
               if (beat !== exp)
                  value_error($sformatf("ack beat %h, expected %h", beat, exp));
            end else
               value_error($sformatf("output beat %h with nothing expected", beat));
            out_first = o_o_tlast;
         end
      end
   end

endmodule

// ==== bench/noc_shell_tb.sv ====
`timescale 1ns/10ps

module noc_shell_tb;

   // Packet counts of all tests, used for the watchdog
   localparam int TOTAL_PKTS = 61;

   logic        clk;
   logic        reset;
   logic [63:0] i_i_tdata;
   logic        i_i_tlast;
   logic        i_i_tvalid;
   logic        o_i_tready;
   logic [63:0] o_o_tdata;
   logic        o_o_tlast;
   logic        o_o_tvalid;
   logic        i_o_tready;
   logic [63:0] o_str_sink_tdata;
   logic        o_str_sink_tlast;
   logic        o_str_sink_tvalid;
   logic        i_str_sink_tready;
   logic [63:0] i_str_src_tdata;
   logic        i_str_src_tlast;
   logic        i_str_src_tvalid;
   logic        o_str_src_tready;
   logic        o_set_stb;
   logic [7:0]  o_set_addr;
   logic [31:0] o_set_data;
   logic        i_rb_stb;
   logic [63:0] i_rb_data;
   logic [7:0]  o_rb_addr;
   logic [15:0] o_src_sid;
   logic [15:0] o_next_dst_sid;
   logic        o_clear_tx_seqnum;
   logic [31:0] rng_state;
   logic [11:0] seq;

   noc_shell noc_shell_i (.*);
   noc_shell_checker chk (.*);

   bind noc_shell noc_shell_properties noc_shell_properties_i (.*);

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Random back-pressure, ready about three cycles in four
   always @(posedge clk) begin
      i_o_tready        <= (xorshift() % 4) != 0;
      i_str_sink_tready <= (xorshift() % 4) != 0;
   end

   initial begin
      repeat (TOTAL_PKTS * 40) @(posedge clk);
      $display("Timeout: the tests did not finish in %0d cycles", TOTAL_PKTS * 40);
      $display("** FAIL **");
      $finish;
   end

   task automatic send_packet(input logic [1:0] ptype, input int beats, input logic [63:0] word);
      logic [63:0] hdr;
      hdr = {ptype, 2'd0, seq, 16'(beats * 8), xorshift()};
      seq = seq + 1;
      @(posedge clk);
      for (int b = 0; b < beats; b++) begin
         i_i_tdata  <= (b == 0) ? hdr : (ptype == 2'd2) ? word : {xorshift(), xorshift()};
         i_i_tlast  <= (b == beats - 1);
         i_i_tvalid <= 1'b1;
         do @(negedge clk); while (!o_i_tready);
         @(posedge clk);
      end
      i_i_tvalid <= 1'b0;
   endtask

   task automatic send_src(input int beats);
      @(posedge clk);
      for (int b = 0; b < beats; b++) begin
         i_str_src_tdata  <= {xorshift(), xorshift()};
         i_str_src_tlast  <= (b == beats - 1);
         i_str_src_tvalid <= 1'b1;
         do @(negedge clk); while (!o_str_src_tready);
         @(posedge clk);
      end
      i_str_src_tvalid <= 1'b0;
   endtask

   // One command, then the user readback pulse after a random delay
   task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data);
      int delay;
      send_packet(2'd2, 2, {24'd0, addr, data});
      do @(negedge clk); while (!o_set_stb);
      delay = xorshift() % 6;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      i_rb_data <= {xorshift(), xorshift()};
      i_rb_stb  <= 1'b1;
      @(posedge clk);
      i_rb_stb  <= 1'b0;
   endtask

   task automatic wait_idle();
      do @(negedge clk); while (!chk.idle() || o_o_tvalid);
   endtask

   initial begin
      rng_state        = 32'd68;
      seq              = '0;
      reset            = 1'b1;
      i_i_tdata        = '0;
      i_i_tlast        = 1'b0;
      i_i_tvalid       = 1'b0;
      i_o_tready       = 1'b0;
      i_str_sink_tready = 1'b0;
      i_str_src_tdata  = '0;
      i_str_src_tlast  = 1'b0;
      i_str_src_tvalid = 1'b0;
      i_rb_stb         = 1'b0;
      i_rb_data        = '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      for (int p = 0; p < 16; p++)
         send_packet(2'd0, 1 + xorshift() % 8, '0);
      wait_idle();
      chk.end_test("data packets");

      for (int p = 0; p < 20; p++)
         send_packet((xorshift() % 2) ? 2'd0 : 2'(1 + 2 * (xorshift() % 2)),
                     1 + xorshift() % 8, '0);
      wait_idle();
      chk.end_test("dropped types");

      fork
         for (int p = 0; p < 8; p++)
            send_src(1 + xorshift() % 8);
         for (int p = 0; p < 4; p++)
            send_cmd(8'd128, xorshift());
      join
      wait_idle();
      chk.end_test("source and ack merge");

      send_cmd(8'd128, xorshift());
      send_cmd(8'd129, xorshift());
      send_cmd(8'd124, 32'd4);
      send_cmd(8'd128, xorshift());
      send_cmd(8'd129, xorshift());
      wait_idle();
      chk.end_test("SID registers");

      send_cmd(8'd124, 32'd0);
      send_cmd(8'd124, 32'd1);
      send_cmd(8'd124, 32'd3);
      wait_idle();
      chk.end_test("readback selects");

      send_cmd(8'd124, 32'd5);
      send_cmd(8'd125, xorshift());
      send_cmd(8'd130, 32'd1);
      send_cmd(8'd12, xorshift());
      send_cmd(8'd125, xorshift());
      wait_idle();
      chk.end_test("user readback");

      $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
               chk.test_num, chk.tests_failed, chk.err_count,
               noc_shell_i.noc_shell_properties_i.fail_count);
      if (chk.err_count == 0 && noc_shell_i.noc_shell_properties_i.fail_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+hw
hw/chdr_pkg.sv
hw/shell_regs_pkg.sv
hw/noc_shell_ifs.sv
hw/pkt_type_demux.sv
hw/cmd_pkt_proc.sv
hw/shell_regs.sv
hw/pkt_out_arbiter.sv
hw/noc_shell.sv
bench/noc_shell_properties.sv
bench/noc_shell_checker.sv
bench/noc_shell_tb.sv
